// ==== tb.f ====
hw/fpu_pkg.sv
hw/fpu_align_stage.sv
hw/fpu_arith_stage.sv
hw/fpu_normalize_stage.sv
hw/fpu_pipeline.sv
test/fpu_pipeline_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module fpu_pipeline_tb \
        -f tb.f -o fpu_pipeline_sim \
    && ./obj_dir/fpu_pipeline_sim \
    || exit 1

// ==== test/fpu_pipeline_tb.sv ====
module fpu_pipeline_tb;
    import fpu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int ROUNDS = 16;
    localparam int GAP_REQUESTS = 16;
    // Reset, settling and drain, thirteen requests per round, up to four cycles per gap request
    localparam int REQUEST_SLOTS = 16 + ROUNDS * 13 + GAP_REQUESTS * 4;
    localparam scalar_t CANONICAL_NAN = 32'h7fffffff;

    logic clk = 1'b0;
    logic reset;
    fpu_request_t req;
    fpu_result_t rsp;
    logic [31:0] lcg_state = 32'ha19;
    fpu_tag_t next_tag = '0;
    fpu_result_t expected_q[$];

    fpu_pipeline UUT(
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp));

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic scalar_t random_float(int lo_exp, int hi_exp);
        logic [31:0] bits;
        int exponent;
        bits = next_random();
        exponent = lo_exp + int'(next_random() % 32'(hi_exp - lo_exp + 1));
        return {bits[31], exponent[7:0], bits[22:0]};
    endfunction

    function automatic scalar_t near_float(scalar_t base, int spread);
        int exponent;
        exponent = int'(base[30:23]) - spread + int'(next_random() % 32'(2 * spread + 1));
        return random_float(exponent, exponent);
    endfunction

    // Exponent 0 gives a subnormal, 8'hff a NaN
    function automatic scalar_t special_operand(logic [7:0] exponent);
        logic [31:0] bits;
        bits = next_random();
        return {bits[31], exponent, bits[22:0] | 23'h1};
    endfunction

    function automatic real to_real(scalar_t value);
        logic [10:0] exponent;
        if (value[30:23] == 8'd0)
            return 0.0;
        exponent = value[30:23] == 8'hff ? 11'h7ff : 11'(value[30:23]) + 11'd896;
        return $bitstoreal({value[31], exponent, value[22:0], 29'd0});
    endfunction

    // Double to single with round to nearest even, overflow to infinity, underflow to +0
    function automatic scalar_t to_float(real value);
        logic [63:0] bits;
        logic [24:0] kept;
        logic round_up;
        int exponent;
        if (value == 0.0)
            return 32'd0;
        bits = $realtobits(value);
        exponent = int'(bits[62:52]) - 896;
        round_up = bits[28] && (|bits[27:0] || bits[29]);
        kept = {2'b01, bits[51:29]} + 25'(round_up);
        if (kept[24])
        begin
            exponent++;
            kept = kept >> 1;
        end
        if (exponent >= 255)
            return {bits[63], 8'hff, 23'd0};
        if (exponent <= 0)
            return 32'd0;
        return {bits[63], exponent[7:0], kept[22:0]};
    endfunction

    function automatic scalar_t expected_lane(fpu_op_t op, scalar_t a, scalar_t b);
        logic [63:0] product;
        scalar_t b_eff;
        logic a_inf;
        logic b_inf;
        logic any_nan;
        real ra;
        real rb;
        product = {32'd0, a} * {32'd0, b};
        b_eff = op == OP_SUB_F ? {~b[31], b[30:0]} : b;
        a_inf = a[30:0] == {8'hff, 23'd0};
        b_inf = b[30:0] == {8'hff, 23'd0};
        any_nan = (&a[30:23] && a[22:0] != '0) || (&b[30:23] && b[22:0] != '0);
        ra = to_real(a);
        rb = to_real(b_eff);
        case (op)
            OP_MULL_I: return product[31:0];
            OP_MULH_U: return product[63:32];
            OP_FTOI:
            begin
                if ((&a[30:23] && a[22:0] != '0) || a[30:23] >= 8'd158)
                    return 32'h80000000;
                return scalar_t'($rtoi(ra));
            end
            OP_ADD_F, OP_SUB_F:
            begin
                if (any_nan || (a_inf && b_inf && a[31] != b_eff[31]))
                    return CANONICAL_NAN;
                if (a_inf)
                    return a;
                if (b_inf)
                    return b_eff;
                return to_float(ra + rb);
            end
            OP_MUL_F:
            begin
                if (any_nan || (a_inf && rb == 0.0) || (b_inf && ra == 0.0))
                    return CANONICAL_NAN;
                if (a_inf || b_inf)
                    return {a[31] ^ b[31], 8'hff, 23'd0};
                return to_float(ra * rb);
            end
            default: ;
        endcase
        // An unordered pair makes every compare false
        if (any_nan)
            return 32'd0;
        case (op)
            OP_CMPGT_F: return scalar_t'(ra > rb);
            OP_CMPGE_F: return scalar_t'(ra >= rb);
            OP_CMPLT_F: return scalar_t'(ra < rb);
            OP_CMPLE_F: return scalar_t'(ra <= rb);
            OP_CMPEQ_F: return scalar_t'(ra == rb);
            default: return scalar_t'(ra != rb);
        endcase
    endfunction

    task automatic stop_with_failure(string reason);
        $display("Test failures found");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(string name, logic [31:0] actual, logic [31:0] expected);
        $display("[ERROR] %0t %s: got %h expected %h", $time, name, actual, expected);
        stop_with_failure("Output value mismatch");
    endtask

    task automatic send_request(fpu_op_t op, vector_t a, vector_t b);
        fpu_result_t expected;
        @(negedge clk);
        req = '{valid: 1'b1, op: op, tag: next_tag, operand_a: a, operand_b: b};
        expected.valid = 1'b1;
        expected.tag = next_tag;
        for (int i = 0; i < NUM_LANES; i++)
            expected.result[i] = expected_lane(op, a[i], b[i]);
        expected_q.push_back(expected);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle_cycles(int count);
        repeat (count)
        begin
            @(negedge clk);
            req.valid = 1'b0;
        end
    endtask

    // Each request leaves the pipeline exactly three edges after it enters
    assert property (@(posedge clk) disable iff (reset) rsp.valid == $past(req.valid, 3))
    else
    begin
        $display("[ERROR] %0t rsp.valid: got %b expected %b", $time,
            $sampled(rsp.valid), !$sampled(rsp.valid));
        stop_with_failure("rsp.valid did not follow req.valid by three cycles");
    end

    // Scoreboard samples on the falling edge where rsp is stable
    always @(negedge clk)
    begin
        fpu_result_t head;
        if (!reset && rsp.valid)
        begin
            assert (expected_q.size() != 0)
                else stop_with_failure("A response arrived with no request outstanding");
            head = expected_q.pop_front();
            assert (rsp.tag == head.tag)
                else report_mismatch("rsp.tag", 32'(rsp.tag), 32'(head.tag));
            for (int i = 0; i < NUM_LANES; i++)
            begin
                assert (rsp.result[i] == head.result[i])
                    else report_mismatch($sformatf("rsp.result[%0d]", i), rsp.result[i],
                        head.result[i]);
            end
        end
    end

    initial
    begin
        #((REQUEST_SLOTS + 20) * CLK_PERIOD);
        stop_with_failure("Watchdog expired before all responses came back");
    end

    initial
    begin
        vector_t a;
        vector_t b;
        fpu_op_t special_op;
        req = '0;
        // A valid request during reset must never reach rsp
        req.valid = 1'b1;
        reset = 1'b1;
        @(negedge clk);
        req.valid = 1'b0;
        for (int cycle = 0; cycle < 4; cycle++)
        begin
            if (cycle == 3)
                reset = 1'b0;
            @(negedge clk);
            assert (rsp.valid == 1'b0)
                else report_mismatch("rsp.valid", 32'(rsp.valid), 32'd0);
        end

        for (int round_index = 0; round_index < ROUNDS; round_index++)
        begin
            // Lane 3 adds a subnormal, which reads as zero
            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = random_float(64, 190);
                b[i] = near_float(a[i], 20);
            end
            a[3] = special_operand(8'd0);
            send_request(OP_ADD_F, a, b);
            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = random_float(64, 190);
                b[i] = near_float(a[i], 20);
            end
            b[3] = a[3];
            send_request(OP_SUB_F, a, b);

            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = random_float(100, 154);
                b[i] = random_float(100, 154);
            end
            a[3] = special_operand(8'd0);
            send_request(OP_MUL_F, a, b);
            // Overflow in lanes 0 and 1, underflow in lanes 2 and 3
            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = i < 2 ? random_float(200, 254) : random_float(1, 50);
                b[i] = i < 2 ? random_float(200, 254) : random_float(1, 50);
            end
            send_request(OP_MUL_F, a, b);

            for (int cmp = int'(OP_CMPGT_F); cmp <= int'(OP_CMPNE_F); cmp++)
            begin
                a[0] = random_float(1, 254);
                b[0] = random_float(1, 254);
                a[1] = random_float(1, 254);
                b[1] = a[1];
                a[2] = {round_index[0], 31'd0};
                b[2] = {~round_index[0], 31'd0};
                a[3] = round_index[0] ? special_operand(8'hff) : random_float(1, 254);
                b[3] = round_index[0] ? random_float(1, 254) : special_operand(8'hff);
                send_request(fpu_op_t'(cmp), a, b);
            end

            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = random_float(100, 165);
                b[i] = next_random();
            end
            a[3] = special_operand(8'hff);
            send_request(OP_FTOI, a, b);

            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = next_random();
                b[i] = next_random();
            end
            send_request(round_index[0] ? OP_MULH_U : OP_MULL_I, a, b);

            // NaN operand, inf - inf or inf * 0, then infinity against a finite value
            special_op = round_index % 3 == 0 ? OP_ADD_F
                : (round_index % 3 == 1 ? OP_SUB_F : OP_MUL_F);
            a[0] = special_operand(8'hff);
            b[0] = random_float(1, 254);
            a[1] = {round_index[1], 8'hff, 23'd0};
            if (special_op == OP_MUL_F)
                b[1] = {round_index[2], 31'd0};
            else
                b[1] = {round_index[1] ^ (special_op == OP_ADD_F), 8'hff, 23'd0};
            a[2] = random_float(1, 254);
            b[2] = {round_index[1], 8'hff, 23'd0};
            a[3] = {round_index[2], 8'hff, 23'd0};
            b[3] = random_float(1, 254);
            send_request(special_op, a, b);
        end

        // Idle cycles between requests must not disturb tag order
        for (int n = 0; n < GAP_REQUESTS; n++)
        begin
            idle_cycles(int'(next_random() % 32'd4));
            for (int i = 0; i < NUM_LANES; i++)
            begin
                a[i] = random_float(64, 190);
                b[i] = near_float(a[i], 20);
            end
            send_request(OP_ADD_F, a, b);
        end
        idle_cycles(1);
        while (expected_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);

        $display("All tests passed!");
        $finish;
    end
endmodule

// ==== hw/fpu_pipeline.sv ====
module fpu_pipeline(
    input logic clk,
    input logic reset,
    input fpu_pkg::fpu_request_t req,
    output fpu_pkg::fpu_result_t rsp);

    import fpu_pkg::*;

    align_stage_t align_out;
    arith_stage_t arith_out;

    // Unpack, special values and alignment
    fpu_align_stage align_stage(
        .clk(clk),
        .reset(reset),
        .req(req),
        .align_out(align_out));

    // Significand add, leading zero count and products
    fpu_arith_stage arith_stage(
        .clk(clk),
        .reset(reset),
        .align_in(align_out),
        .arith_out(arith_out));

    // Normalize, round and pick the lane result
    fpu_normalize_stage normalize_stage(
        .clk(clk),
        .reset(reset),
        .arith_in(arith_out),
        .rsp(rsp));
endmodule

// ==== hw/fpu_normalize_stage.sv ====
module fpu_normalize_stage(
    input logic clk,
    input logic reset,
    input fpu_pkg::arith_stage_t arith_in,
    output fpu_pkg::fpu_result_t rsp);

    import fpu_pkg::*;

    vector_t result_next;
    logic valid_q;
    fpu_tag_t tag_q;
    vector_t result_q;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_gen
            arith_lane_t lane_in;
            logic [27:0] shifted_sum;
            logic add_round_up;
            logic [23:0] add_rounded;
            logic signed [9:0] add_exp;
            logic sum_zero;
            scalar_t add_result;
            logic mul_hi;
            logic [22:0] mul_frac;
            logic mul_guard;
            logic mul_round;
            logic [21:0] mul_sticky_bits;
            logic mul_round_up;
            logic [23:0] mul_rounded;
            logic signed [9:0] mul_exp;
            logic mul_zero;
            scalar_t fmul_result;
            logic compare_result;

            assign lane_in = arith_in.lanes[lane];

            // Leading one ends up in bit 27, guard at bit 3
            assign shifted_sum = lane_in.add_significand << lane_in.norm_shift;
            assign add_round_up = shifted_sum[3]
                && (shifted_sum[2] || |shifted_sum[1:0] || shifted_sum[4]);
            assign add_rounded = {1'b0, shifted_sum[26:4]} + 24'(add_round_up);
            assign add_exp = $signed({2'b00, lane_in.add_exponent}) + 10'sd1
                - $signed({5'd0, lane_in.norm_shift}) + $signed({9'd0, add_rounded[23]});
            assign sum_zero = lane_in.add_significand == '0;

            always_comb
            begin
                if (lane_in.result_nan)
                    add_result = 32'h7fffffff;
                else if (lane_in.result_inf)
                    add_result = {lane_in.add_sign, 8'hff, 23'd0};
                else if (sum_zero)
                begin
                    // Cancellation gives +0; only -0 + -0 keeps the minus sign
                    add_result = {lane_in.add_sign && !lane_in.logical_subtract, 31'd0};
                end
                else if (add_exp >= 10'sd255)
                    add_result = {lane_in.add_sign, 8'hff, 23'd0};
                else if (add_exp <= 10'sd0)
                    add_result = '0;
                else
                    add_result = {lane_in.add_sign, add_exp[7:0], add_rounded[22:0]};
            end

            // Normal significands give a product in [1, 4), so at most one place of shift
            assign mul_hi = lane_in.significand_product[47];
            assign {mul_frac, mul_guard, mul_round, mul_sticky_bits} = mul_hi
                ? lane_in.significand_product[46:0]
                : {lane_in.significand_product[45:0], 1'b0};
            assign mul_round_up = mul_guard && (mul_round || |mul_sticky_bits || mul_frac[0]);
            assign mul_rounded = {1'b0, mul_frac} + 24'(mul_round_up);
            assign mul_exp = $signed(lane_in.mul_exponent) + $signed({9'd0, mul_hi})
                + $signed({9'd0, mul_rounded[23]});
            assign mul_zero = !lane_in.significand_product[47] && !lane_in.significand_product[46];

            always_comb
            begin
                if (lane_in.result_nan)
                    fmul_result = 32'h7fffffff;
                else if (lane_in.result_inf)
                    fmul_result = {lane_in.mul_sign, 8'hff, 23'd0};
                else if (mul_zero || mul_exp <= 10'sd0)
                    fmul_result = '0;
                else if (mul_exp >= 10'sd255)
                    fmul_result = {lane_in.mul_sign, 8'hff, 23'd0};
                else
                    fmul_result = {lane_in.mul_sign, mul_exp[7:0], mul_rounded[22:0]};
            end

            // Unordered operands make every compare false
            always_comb
            begin
                case (arith_in.op)
                    OP_CMPGT_F: compare_result = !lane_in.add_sign && !sum_zero;
                    OP_CMPGE_F: compare_result = !lane_in.add_sign || sum_zero;
                    OP_CMPLT_F: compare_result = lane_in.add_sign && !sum_zero;
                    OP_CMPLE_F: compare_result = lane_in.add_sign || sum_zero;
                    OP_CMPEQ_F: compare_result = sum_zero;
                    OP_CMPNE_F: compare_result = !sum_zero;
                    default: compare_result = 1'b0;
                endcase
                if (lane_in.result_nan)
                    compare_result = 1'b0;
            end

            always_comb
            begin
                case (arith_in.op)
                    OP_CMPGT_F, OP_CMPGE_F, OP_CMPLT_F, OP_CMPLE_F, OP_CMPEQ_F, OP_CMPNE_F:
                        result_next[lane] = scalar_t'(compare_result);
                    OP_MULL_I: result_next[lane] = lane_in.significand_product[31:0];
                    OP_MULH_U: result_next[lane] = lane_in.significand_product[63:32];
                    OP_FTOI:
                        result_next[lane] = lane_in.ftoi_invalid ? 32'h80000000
                            : lane_in.ftoi_value;
                    OP_MUL_F: result_next[lane] = fmul_result;
                    default: result_next[lane] = add_result;
                endcase
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        tag_q <= arith_in.tag;
        result_q <= result_next;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= arith_in.valid;
    end

    assign rsp = '{valid: valid_q, tag: tag_q, result: result_q};
endmodule

// ==== hw/fpu_arith_stage.sv ====
module fpu_arith_stage(
    input logic clk,
    input logic reset,
    input fpu_pkg::align_stage_t align_in,
    output fpu_pkg::arith_stage_t arith_out);

    import fpu_pkg::*;

    arith_lane_t [NUM_LANES - 1:0] lane_next;
    logic valid_q;
    fpu_op_t op_q;
    fpu_tag_t tag_q;
    arith_lane_t [NUM_LANES - 1:0] lanes_q;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_gen
            align_lane_t lane_in;
            logic [27:0] sum;
            logic [4:0] leading_zeros;
            logic [63:0] product;

            assign lane_in = align_in.lanes[lane];

            // Extra top bit holds the carry of a logical add
            always_comb
            begin
                if (lane_in.logical_subtract)
                    sum = {1'b0, lane_in.large_significand} - {1'b0, lane_in.small_significand};
                else
                    sum = {1'b0, lane_in.large_significand} + {1'b0, lane_in.small_significand};
            end

            // Highest set bit wins, so scan upward
            always_comb
            begin
                leading_zeros = 5'd28;
                for (int i = 0; i < 28; i++)
                begin
                    if (sum[i])
                        leading_zeros = 5'(27 - i);
                end
            end

            // One multiplier serves fmul significands and both integer multiplies
            assign product = {32'd0, lane_in.int_operand_a} * {32'd0, lane_in.int_operand_b};

            always_comb
            begin
                lane_next[lane].result_nan = lane_in.result_nan;
                lane_next[lane].result_inf = lane_in.result_inf;
                lane_next[lane].add_exponent = lane_in.add_exponent;
                lane_next[lane].add_significand = sum;
                lane_next[lane].add_sign = lane_in.add_sign;
                lane_next[lane].logical_subtract = lane_in.logical_subtract;
                lane_next[lane].norm_shift = leading_zeros;
                lane_next[lane].significand_product = product;
                lane_next[lane].mul_exponent = lane_in.mul_exponent;
                lane_next[lane].mul_sign = lane_in.mul_sign;
                if (lane_in.add_sign)
                    lane_next[lane].ftoi_value = -lane_in.int_operand_a;
                else
                    lane_next[lane].ftoi_value = lane_in.int_operand_a;
                lane_next[lane].ftoi_invalid = lane_in.ftoi_invalid;
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        op_q <= align_in.op;
        tag_q <= align_in.tag;
        lanes_q <= lane_next;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= align_in.valid;
    end

    assign arith_out = '{valid: valid_q, op: op_q, tag: tag_q, lanes: lanes_q};
endmodule

// ==== hw/fpu_align_stage.sv ====
module fpu_align_stage(
    input logic clk,
    input logic reset,
    input fpu_pkg::fpu_request_t req,
    output fpu_pkg::align_stage_t align_out);

    import fpu_pkg::*;

    logic is_mul;
    logic is_compare;
    logic negate_b;
    align_lane_t [NUM_LANES - 1:0] lane_next;
    logic valid_q;
    fpu_op_t op_q;
    fpu_tag_t tag_q;
    align_lane_t [NUM_LANES - 1:0] lanes_q;

    assign is_mul = req.op == OP_MUL_F;
    assign is_compare = req.op inside {OP_CMPGT_F, OP_CMPGE_F, OP_CMPLT_F, OP_CMPLE_F,
        OP_CMPEQ_F, OP_CMPNE_F};

    // Compares are computed as a - b
    assign negate_b = req.op == OP_SUB_F || is_compare;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_gen
            logic sign_a;
            logic sign_b;
            logic sign_b_eff;
            logic [FLOAT32_EXP_WIDTH - 1:0] exp_a;
            logic [FLOAT32_EXP_WIDTH - 1:0] exp_b;
            logic [FLOAT32_SIG_WIDTH - 1:0] frac_a;
            logic [FLOAT32_SIG_WIDTH - 1:0] frac_b;
            logic a_zero;
            logic b_zero;
            logic a_inf;
            logic b_inf;
            logic a_nan;
            logic b_nan;
            logic [23:0] sig_a;
            logic [23:0] sig_b;
            logic a_larger;
            logic [7:0] exp_diff;
            logic [4:0] shift_amount;
            logic [53:0] small_ext;
            scalar_t ftoi_mag;
            logic result_nan;

            assign {sign_a, exp_a, frac_a} = req.operand_a[lane];
            assign {sign_b, exp_b, frac_b} = req.operand_b[lane];
            assign sign_b_eff = sign_b ^ negate_b;

            // Subnormals are read as zero
            assign a_zero = exp_a == '0;
            assign b_zero = exp_b == '0;
            assign a_inf = &exp_a && frac_a == '0;
            assign b_inf = &exp_b && frac_b == '0;
            assign a_nan = &exp_a && frac_a != '0;
            assign b_nan = &exp_b && frac_b != '0;
            assign sig_a = a_zero ? 24'd0 : {1'b1, frac_a};
            assign sig_b = b_zero ? 24'd0 : {1'b1, frac_b};

            assign a_larger = {exp_a, sig_a} >= {exp_b, sig_b};
            assign exp_diff = a_larger ? exp_a - exp_b : exp_b - exp_a;
            assign shift_amount = exp_diff > 8'd27 ? 5'd27 : exp_diff[4:0];

            // Lower half catches everything shifted out, folded into sticky below
            assign small_ext = {(a_larger ? sig_b : sig_a), 3'b000, 27'd0} >> shift_amount;

            // Integer point sits at exponent 150, where the hidden bit has weight 2^23
            always_comb
            begin
                if (exp_a >= 8'd150)
                    ftoi_mag = {8'd0, sig_a} << (exp_a - 8'd150);
                else
                    ftoi_mag = {8'd0, sig_a} >> (8'd150 - exp_a);
            end

            always_comb
            begin
                if (is_mul)
                    result_nan = a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero);
                else
                    result_nan = a_nan || b_nan
                        || (!is_compare && a_inf && b_inf && sign_a != sign_b_eff);
            end

            always_comb
            begin
                lane_next[lane].result_nan = result_nan;
                lane_next[lane].result_inf = (a_inf || b_inf) && !result_nan;
                lane_next[lane].add_exponent = a_larger ? exp_a : exp_b;
                if (req.op == OP_FTOI)
                    lane_next[lane].add_sign = sign_a;
                else
                    lane_next[lane].add_sign = a_larger ? sign_a : sign_b_eff;
                lane_next[lane].logical_subtract = sign_a ^ sign_b_eff;
                lane_next[lane].large_significand = {(a_larger ? sig_a : sig_b), 3'b000};
                lane_next[lane].small_significand = {small_ext[53:28],
                    small_ext[27] | (|small_ext[26:0])};
                lane_next[lane].mul_exponent = $signed({2'b00, exp_a})
                    + $signed({2'b00, exp_b}) - 10'sd127;
                lane_next[lane].mul_sign = sign_a ^ sign_b;
                if (req.op == OP_FTOI)
                    lane_next[lane].int_operand_a = ftoi_mag;
                else if (is_mul)
                    lane_next[lane].int_operand_a = {8'd0, sig_a};
                else
                    lane_next[lane].int_operand_a = req.operand_a[lane];
                lane_next[lane].int_operand_b = is_mul ? {8'd0, sig_b} : req.operand_b[lane];
                lane_next[lane].ftoi_invalid = a_nan || exp_a >= 8'd158;
            end
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        op_q <= req.op;
        tag_q <= req.tag;
        lanes_q <= lane_next;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= req.valid;
    end

    assign align_out = '{valid: valid_q, op: op_q, tag: tag_q, lanes: lanes_q};
endmodule

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;
    localparam int NUM_LANES = 4;
    localparam int FLOAT32_EXP_WIDTH = 8;
    localparam int FLOAT32_SIG_WIDTH = 23;

    typedef logic [31:0] scalar_t;
    typedef scalar_t [NUM_LANES - 1:0] vector_t;

    typedef enum logic [3:0] {
        OP_ADD_F,
        OP_SUB_F,
        OP_MUL_F,
        OP_CMPGT_F,
        OP_CMPGE_F,
        OP_CMPLT_F,
        OP_CMPLE_F,
        OP_CMPEQ_F,
        OP_CMPNE_F,
        OP_FTOI,
        OP_MULL_I,
        OP_MULH_U
    } fpu_op_t;

    typedef logic [3:0] fpu_tag_t;

    typedef struct packed {
        logic valid;
        fpu_op_t op;
        fpu_tag_t tag;
        vector_t operand_a;
        vector_t operand_b;
    } fpu_request_t;

    typedef struct packed {
        logic valid;
        fpu_tag_t tag;
        vector_t result;
    } fpu_result_t;

    typedef struct packed {
        logic result_nan;
        logic result_inf;
        logic [FLOAT32_EXP_WIDTH - 1:0] add_exponent;
        logic add_sign;
        logic logical_subtract;
        // Hidden bit, fraction, guard, round, sticky
        logic [26:0] large_significand;
        logic [26:0] small_significand;
        logic signed [9:0] mul_exponent;
        logic mul_sign;
        // Multiplier inputs; ftoi magnitude rides in int_operand_a
        scalar_t int_operand_a;
        scalar_t int_operand_b;
        logic ftoi_invalid;
    } align_lane_t;

    typedef struct packed {
        logic valid;
        fpu_op_t op;
        fpu_tag_t tag;
        align_lane_t [NUM_LANES - 1:0] lanes;
    } align_stage_t;

    typedef struct packed {
        logic result_nan;
        logic result_inf;
        logic [FLOAT32_EXP_WIDTH - 1:0] add_exponent;
        logic [27:0] add_significand;
        logic add_sign;
        logic logical_subtract;
        logic [4:0] norm_shift;
        logic [63:0] significand_product;
        logic signed [9:0] mul_exponent;
        logic mul_sign;
        scalar_t ftoi_value;
        logic ftoi_invalid;
    } arith_lane_t;

    typedef struct packed {
        logic valid;
        fpu_op_t op;
        fpu_tag_t tag;
        arith_lane_t [NUM_LANES - 1:0] lanes;
    } arith_stage_t;
endpackage
